/* Bender.yml */
package:
  name: serv_trim

sources:
  - verilog/serv_pkg.sv
  - verilog/serv_cnt_if.sv
  - verilog/serv_alu_if.sv
  - verilog/serv_state.sv
  - verilog/serv_decode.sv
  - verilog/serv_alu.sv
  - verilog/serv_ctrl.sv
  - verilog/serv_rf_if.sv
  - verilog/serv_top.sv
  - target: test
    files:
      - tests/tb_serv_top.sv

/* build.f */
verilog/serv_pkg.sv
verilog/serv_cnt_if.sv
verilog/serv_alu_if.sv
verilog/serv_state.sv
verilog/serv_decode.sv
verilog/serv_alu.sv
verilog/serv_ctrl.sv
verilog/serv_rf_if.sv
verilog/serv_top.sv
tests/tb_serv_top.sv

/* tests/tb_serv_top.sv */
`timescale 1ns/1ps

module tb_serv_top;

   localparam int NUM_INSTR  = 200;
   localparam int MEM_WORDS  = 256;
   localparam int MAX_CYCLES = NUM_INSTR * (32 + 3 + 3 + 6) + 20;

   logic        i_clk;
   logic        i_rst_n;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic        o_rf_rreq;
   logic        i_rf_ready;
   logic [4:0]  o_rreg0;
   logic [4:0]  o_rreg1;
   logic        i_rdata0;
   logic        i_rdata1;
   logic [4:0]  o_wreg0;
   logic        o_wen0;
   logic        o_wdata0;

   logic [31:0] mem [MEM_WORDS];
   logic [31:0] rf_regs [32];
   logic [31:0] model_regs [32];
   logic [31:0] model_pc;
   logic [31:0] rng;
   int          errors = 0;
   int          retired = 0;
   int          cycles = 0;

   serv_top i_serv_top (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_rf_rreq  (o_rf_rreq),
      .i_rf_ready (i_rf_ready),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_wreg0    (o_wreg0),
      .o_wen0     (o_wen0),
      .o_wdata0   (o_wdata0)
   );

   always #2 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES) begin
         $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
         $display("instructions: %0d, errors: %0d", retired, errors);
         $display("sim failed");
         $finish;
      end
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Kept subset with a shift, a branch and an rd = x0 case mixed in
   function automatic logic [31:0] random_instr();
      logic [31:0] r;
      logic [2:0]  f3;
      r = next_rand();
      case (r[14:13])
         2'd0:    f3 = 3'b000;
         2'd1:    f3 = 3'b100;
         2'd2:    f3 = 3'b110;
         default: f3 = 3'b111;
      endcase
      case (next_rand() % 12)
         0, 1, 2: return {1'b0, r[30] & (f3 == 3'b000), 5'b0, r[24:15], f3, r[11:7], 7'b0110011};
         3, 4, 5: return {r[31:15], f3, r[11:7], 7'b0010011};
         6:       return {r[31:12], r[11:7], 7'b0110111};
         7:       return {r[31:12], r[11:7], 7'b0010111};
         8:       return {r[31:22], 1'b0, r[20:12], r[11:7], 7'b1101111};
         9:       return {7'b0, r[24:15], 3'b001, r[11:7], 7'b0010011};
         10:      return {r[31:7], 7'b1100011};
         default: return {7'b0, r[24:15], f3, 5'b0, 7'b0110011};
      endcase
   endfunction

   task automatic model_exec(input logic [31:0] ins, output logic wr, output logic [31:0] res,
                             output logic [31:0] pc_next);
      logic [31:0] a;
      logic [31:0] b;
      logic [2:0]  f3;
      logic        f3_ok;
      a = model_regs[ins[19:15]];
      f3 = ins[14:12];
      f3_ok = (f3 == 3'b000) || (f3 == 3'b100) || (f3 == 3'b110) || (f3 == 3'b111);
      wr = 1'b0;
      res = '0;
      pc_next = model_pc + 32'd4;
      case (ins[6:0])
         7'b0110011, 7'b0010011: begin
            if (ins[5]) begin
               b = model_regs[ins[24:20]];
               wr = f3_ok && ((ins[31:25] == 7'b0) ||
                              ((ins[31:25] == 7'b0100000) && (f3 == 3'b000)));
            end else begin
               b = {{20{ins[31]}}, ins[31:20]};
               wr = f3_ok;
            end
            case (f3)
               3'b100:  res = a ^ b;
               3'b110:  res = a | b;
               3'b111:  res = a & b;
               default: res = (ins[5] && ins[30]) ? a - b : a + b;
            endcase
         end
         7'b0110111: begin
            wr = 1'b1;
            res = {ins[31:12], 12'b0};
         end
         7'b0010111: begin
            wr = 1'b1;
            res = model_pc + {ins[31:12], 12'b0};
         end
         7'b1101111: begin
            wr = 1'b1;
            res = model_pc + 32'd4;
            pc_next = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         default: wr = 1'b0;
      endcase
      if (ins[11:7] == 5'd0)
         wr = 1'b0;
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      errors++;
      $display("FAILED t=%0t %s: expected %h, got %h", $time, name, expected, actual);
   endtask

   task automatic report_error(input string what);
      errors++;
      $display("ERROR t=%0t %s", $time, what);
   endtask

   initial begin
      logic [31:0] ins;
      logic [31:0] rs1_val;
      logic [31:0] rs2_val;
      logic [31:0] exp_res;
      logic [31:0] got_res;
      logic [31:0] pc_next;
      logic [4:0]  got_wreg;
      logic        exp_wr;
      logic        seen_wen;
      int          ack_wait;
      int          rdy_wait;
      i_clk = 1'b0;
      i_rst_n = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_rf_ready = 1'b0;
      i_rdata0 = 1'b0;
      i_rdata1 = 1'b0;
      rng = 32'd24;
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] = random_instr();
      for (int i = 0; i < 32; i++) begin
         rf_regs[i] = (i == 0) ? '0 : next_rand();
         model_regs[i] = rf_regs[i];
      end

      repeat (3) begin
         @(negedge i_clk);
         if (o_ibus_cyc !== 1'b0 || o_rf_rreq !== 1'b0 || o_wen0 !== 1'b0)
            report_error("bus or register file active during reset");
      end
      i_rst_n = 1'b1;
      model_pc = serv_pkg::RESET_PC;

      for (int n = 0; n < NUM_INSTR; n++) begin
         ack_wait = next_rand() % 4;
         rdy_wait = next_rand() % 4;
         // Fetch with wait states before the ack
         while (1) begin
            @(negedge i_clk);
            i_rdata0 = 1'b0;
            i_rdata1 = 1'b0;
            if (o_rf_rreq !== 1'b0 || o_wen0 !== 1'b0)
               report_error("register file request or write outside its window");
            if (o_ibus_cyc === 1'b1) begin
               if (o_ibus_adr !== model_pc)
                  report_mismatch("o_ibus_adr", model_pc, o_ibus_adr);
               if (ack_wait == 0)
                  break;
               ack_wait--;
            end else if (n > 0) begin
               report_error("fetch did not start right after execute");
            end
         end
         ins = mem[model_pc[9:2]];
         i_ibus_ack = 1'b1;
         i_ibus_rdt = ins;

         @(negedge i_clk);
         i_ibus_ack = 1'b0;
         i_ibus_rdt = '0;
         if (o_ibus_cyc !== 1'b0)
            report_error("o_ibus_cyc still high after ack");
         if (o_rf_rreq !== 1'b1)
            report_error("o_rf_rreq not asserted one cycle after ack");
         if (o_rreg0 !== ins[19:15])
            report_mismatch("o_rreg0", ins[19:15], o_rreg0);
         if (o_rreg1 !== ins[24:20])
            report_mismatch("o_rreg1", ins[24:20], o_rreg1);
         repeat (rdy_wait) begin
            @(negedge i_clk);
            if (o_rf_rreq !== 1'b0 || o_wen0 !== 1'b0)
               report_error("register file request or write while waiting for ready");
         end
         i_rf_ready = 1'b1;

         rs1_val = rf_regs[ins[19:15]];
         rs2_val = rf_regs[ins[24:20]];
         model_exec(ins, exp_wr, exp_res, pc_next);
         got_res = '0;
         got_wreg = '0;
         seen_wen = 1'b0;
         // Serial execute with LSB first
         for (int k = 0; k < 32; k++) begin
            @(negedge i_clk);
            i_rf_ready = 1'b0;
            i_rdata0 = rs1_val[k];
            i_rdata1 = rs2_val[k];
            #1;
            if (o_ibus_cyc !== 1'b0 || o_rf_rreq !== 1'b0)
               report_error("bus or register request active during execute");
            if (o_wen0 !== exp_wr)
               report_mismatch("o_wen0", exp_wr, o_wen0);
            if (o_wen0 === 1'b1) begin
               seen_wen = 1'b1;
               got_res[k] = o_wdata0;
               got_wreg = o_wreg0;
               if (o_wreg0 !== ins[11:7])
                  report_mismatch("o_wreg0", ins[11:7], o_wreg0);
            end
         end

         if (exp_wr && got_res !== exp_res)
            report_mismatch("o_wdata0 word", exp_res, got_res);
         if (seen_wen)
            rf_regs[got_wreg] = got_res;
         if (exp_wr)
            model_regs[ins[11:7]] = exp_res;
         if (rf_regs[0] !== '0)
            report_error("register x0 holds a nonzero value");
         model_pc = pc_next;
         retired++;
      end

      @(negedge i_clk);
      if (o_ibus_cyc !== 1'b1)
         report_error("no fetch after the last instruction");
      $display("instructions: %0d, errors: %0d", retired, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* verilog/serv_alu.sv */
`timescale 1ns/1ps

module serv_alu (
   input  logic     i_clk,
   serv_cnt_if.user cnt,
   serv_alu_if.alu  alu,
   input  logic     i_rs1,
   input  logic     i_rs2,
   input  logic     i_imm,
   output logic     o_rd
);

   logic op_b;
   logic op_b_inv;
   logic carry_in;
   logic carry_out;
   logic carry_q;
   logic sum;
   logic bool_rd;

   assign op_b     = alu.op_b_imm ? i_imm : i_rs2;
   assign op_b_inv = op_b ^ alu.sub;

   // Carry of one for two's complement subtraction
   assign carry_in = cnt.cnt0 ? alu.sub : carry_q;

   assign {carry_out, sum} = {1'b0, i_rs1} + {1'b0, op_b_inv} + {1'b0, carry_in};

   always_ff @(posedge i_clk) begin
      if (cnt.cnt_en)
         carry_q <= carry_out;
   end

   always_comb begin
      case (alu.bool_op)
         serv_pkg::BOOL_OR:  bool_rd = i_rs1 | op_b;
         serv_pkg::BOOL_AND: bool_rd = i_rs1 & op_b;
         default:            bool_rd = i_rs1 ^ op_b;
      endcase
   end

   assign o_rd = (alu.rd_sel == serv_pkg::RD_BOOL) ? bool_rd : sum;

   a_ctrl_stable : assert property (@(posedge i_clk)
      (cnt.cnt_en && !cnt.cnt_done) |=>
         $stable({alu.sub, alu.bool_op, alu.rd_sel, alu.op_b_imm}));

endmodule

/* verilog/serv_alu_if.sv */
`timescale 1ns/1ps

interface serv_alu_if;

   logic                  sub;
   serv_pkg::alu_bool_e   bool_op;
   serv_pkg::alu_rd_sel_e rd_sel;
   logic                  op_b_imm;

   modport decoder (
      output sub, bool_op, rd_sel, op_b_imm
   );

   modport alu (
      input sub, bool_op, rd_sel, op_b_imm
   );

endinterface

/* verilog/serv_cnt_if.sv */
`timescale 1ns/1ps

interface serv_cnt_if;

   logic cnt_en;
   logic cnt0;
   logic cnt2;
   logic cnt_done;

   modport state (
      output cnt_en, cnt0, cnt2, cnt_done
   );

   modport user (
      input cnt_en, cnt0, cnt2, cnt_done
   );

endinterface

/* verilog/serv_ctrl.sv */
`timescale 1ns/1ps

module serv_ctrl (
   input  logic                      i_clk,
   input  logic                      i_rst_n,
   serv_cnt_if.user                  cnt,
   input  logic                      i_imm,
   input  logic                      i_pc_rel,
   input  logic                      i_utype,
   input  logic                      i_jal,
   output logic                      o_rd,
   output logic [serv_pkg::XLEN-1:0] o_ibus_adr
);

   logic [serv_pkg::XLEN-1:0] pc_q;
   logic                      pc_bit;
   logic                      plus4;
   logic                      plus4_cy;
   logic                      plus4_cy_q;
   logic                      pc_imm;
   logic                      pc_imm_cy;
   logic                      pc_imm_cy_q;
   logic                      new_pc;

   assign pc_bit = pc_q[0];

   // PC+4, the 4 enters as a single bit at position 2
   assign {plus4_cy, plus4} = {1'b0, pc_bit} + {1'b0, cnt.cnt2} +
                              {1'b0, plus4_cy_q & !cnt.cnt0};

   // PC+imm, or the plain immediate when not PC relative
   assign {pc_imm_cy, pc_imm} = {1'b0, pc_bit & i_pc_rel} + {1'b0, i_imm} +
                                {1'b0, pc_imm_cy_q & !cnt.cnt0};

   assign new_pc = i_jal ? pc_imm : plus4;
   assign o_rd   = i_utype ? pc_imm : plus4;

   always_ff @(posedge i_clk) begin
      if (cnt.cnt_en) begin
         plus4_cy_q  <= plus4_cy;
         pc_imm_cy_q <= pc_imm_cy;
      end
   end

   // Rotates LSB first, holds the next PC once execute is over
   always_ff @(posedge i_clk) begin
      if (!i_rst_n)
         pc_q <= serv_pkg::RESET_PC;
      else if (cnt.cnt_en)
         pc_q <= {new_pc, pc_q[serv_pkg::XLEN-1:1]};
   end

   assign o_ibus_adr = pc_q;

endmodule

/* verilog/serv_decode.sv */
`timescale 1ns/1ps

module serv_decode (
   input  logic                            i_clk,
   input  logic [serv_pkg::XLEN-1:0]       i_ibus_rdt,
   input  logic                            i_ibus_ack,
   serv_cnt_if.user                        cnt,
   serv_alu_if.decoder                     alu,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rs1_addr,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rs2_addr,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rd_addr,
   output logic                            o_rd_wr,
   output logic                            o_imm,
   output logic                            o_ctrl_pc_rel,
   output logic                            o_ctrl_utype,
   output logic                            o_ctrl_jal,
   output logic                            o_rd_ctrl_sel
);

   logic [serv_pkg::XLEN-1:0] instr_q;
   logic [serv_pkg::XLEN-1:0] imm_q;
   logic [serv_pkg::XLEN-1:0] imm_dec;
   serv_pkg::opcode_e         rdt_opc;
   serv_pkg::opcode_e         opc;
   logic [2:0]                funct3;
   logic [6:0]                funct7;
   logic                      funct_ok;
   logic                      op_funct7_ok;

   // Immediate format picked from the word still on the bus
   assign rdt_opc = serv_pkg::opcode_e'(i_ibus_rdt[6:2]);

   always_comb begin
      case (rdt_opc)
         serv_pkg::LUI, serv_pkg::AUIPC:
            imm_dec = {i_ibus_rdt[31:12], 12'b0};
         serv_pkg::JAL:
            imm_dec = {{12{i_ibus_rdt[31]}}, i_ibus_rdt[19:12], i_ibus_rdt[20],
                       i_ibus_rdt[30:21], 1'b0};
         default:
            imm_dec = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_ibus_ack) begin
         instr_q <= i_ibus_rdt;
         imm_q   <= imm_dec;
      end else if (cnt.cnt_en) begin
         imm_q <= {imm_q[serv_pkg::XLEN-1], imm_q[serv_pkg::XLEN-1:1]};
      end
   end

   assign o_imm = imm_q[0];

   assign opc    = serv_pkg::opcode_e'(instr_q[6:2]);
   assign funct3 = instr_q[14:12];
   assign funct7 = instr_q[31:25];

   assign o_rd_addr  = instr_q[11:7];
   assign o_rs1_addr = instr_q[19:15];
   assign o_rs2_addr = instr_q[24:20];

   // ADD/SUB, XOR, OR, AND only, shifts and SLT fall through as no-ops
   assign funct_ok     = (funct3 == 3'b000) || (funct3[2] && (funct3[1:0] != 2'b01));
   assign op_funct7_ok = (funct7 == 7'b0) || ((funct7 == 7'b0100000) && (funct3 == 3'b000));

   assign o_rd_wr = ((opc == serv_pkg::OP) && funct_ok && op_funct7_ok) ||
                    ((opc == serv_pkg::OP_IMM) && funct_ok) ||
                    (opc == serv_pkg::LUI) || (opc == serv_pkg::AUIPC) ||
                    (opc == serv_pkg::JAL);

   assign o_ctrl_pc_rel = (opc == serv_pkg::AUIPC) || (opc == serv_pkg::JAL);
   assign o_ctrl_utype  = (opc == serv_pkg::LUI) || (opc == serv_pkg::AUIPC);
   assign o_ctrl_jal    = (opc == serv_pkg::JAL);
   assign o_rd_ctrl_sel = o_ctrl_utype || o_ctrl_jal;

   assign alu.sub      = (opc == serv_pkg::OP) && instr_q[30];
   assign alu.op_b_imm = (opc == serv_pkg::OP_IMM);
   assign alu.rd_sel   = funct3[2] ? serv_pkg::RD_BOOL : serv_pkg::RD_ADD;

   always_comb begin
      case (funct3[1:0])
         2'b10:   alu.bool_op = serv_pkg::BOOL_OR;
         2'b11:   alu.bool_op = serv_pkg::BOOL_AND;
         default: alu.bool_op = serv_pkg::BOOL_XOR;
      endcase
   end

endmodule

/* verilog/serv_pkg.sv */
package serv_pkg;

   // Datapath and register file geometry
   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;
   localparam int CNT_W      = 5;

   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

   // Major opcodes, instr[6:2]
   typedef enum logic [4:0] {
      OP_IMM = 5'b00100,
      AUIPC  = 5'b00101,
      OP     = 5'b01100,
      LUI    = 5'b01101,
      JAL    = 5'b11011
   } opcode_e;

   // Follows funct3[1:0] of the boolean ops
   typedef enum logic [1:0] {
      BOOL_XOR = 2'b00,
      BOOL_OR  = 2'b10,
      BOOL_AND = 2'b11
   } alu_bool_e;

   typedef enum logic {
      RD_ADD  = 1'b0,
      RD_BOOL = 1'b1
   } alu_rd_sel_e;

   typedef enum logic [1:0] {
      ST_FETCH   = 2'b00,
      ST_RF_REQ  = 2'b01,
      ST_RF_WAIT = 2'b10,
      ST_EXEC    = 2'b11
   } state_e;

endpackage

/* verilog/serv_rf_if.sv */
`timescale 1ns/1ps

module serv_rf_if (
   input  logic                            i_rf_busy,
   input  logic                            i_rd_wr,
   input  logic                            i_rd_ctrl_sel,
   input  logic [serv_pkg::REG_ADDR_W-1:0] i_rd_addr,
   input  logic [serv_pkg::REG_ADDR_W-1:0] i_rs1_addr,
   input  logic [serv_pkg::REG_ADDR_W-1:0] i_rs2_addr,
   input  logic                            i_alu_rd,
   input  logic                            i_ctrl_rd,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_wreg0,
   output logic                            o_wen0,
   output logic                            o_wdata0,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rreg0,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rreg1
);

   // x0 is never written
   assign o_wen0 = i_rf_busy && i_rd_wr && (|i_rd_addr);

   // LUI, AUIPC and JAL take their result from ctrl
   assign o_wdata0 = i_rd_ctrl_sel ? i_ctrl_rd : i_alu_rd;

   assign o_wreg0 = i_rd_addr;
   assign o_rreg0 = i_rs1_addr;
   assign o_rreg1 = i_rs2_addr;

endmodule

/* verilog/serv_state.sv */
`timescale 1ns/1ps

module serv_state (
   input  logic     i_clk,
   input  logic     i_rst_n,
   input  logic     i_ibus_ack,
   input  logic     i_rf_ready,
   output logic     o_ibus_cyc,
   output logic     o_rf_rreq,
   output logic     o_rf_busy,
   serv_cnt_if.state cnt
);

   serv_pkg::state_e           state_q;
   logic [serv_pkg::CNT_W-1:0] cnt_q;

   assign cnt.cnt_en   = (state_q == serv_pkg::ST_EXEC);
   assign cnt.cnt0     = cnt.cnt_en && (cnt_q == 5'd0);
   assign cnt.cnt2     = cnt.cnt_en && (cnt_q == 5'd2);
   assign cnt.cnt_done = cnt.cnt_en && (&cnt_q);

   assign o_rf_rreq = (state_q == serv_pkg::ST_RF_REQ);
   assign o_rf_busy = cnt.cnt_en;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state_q <= serv_pkg::ST_FETCH;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            serv_pkg::ST_FETCH: begin
               if (o_ibus_cyc && i_ibus_ack)
                  state_q <= serv_pkg::ST_RF_REQ;
            end
            // Ready may already come with the request
            serv_pkg::ST_RF_REQ: begin
               state_q <= i_rf_ready ? serv_pkg::ST_EXEC : serv_pkg::ST_RF_WAIT;
            end
            serv_pkg::ST_RF_WAIT: begin
               if (i_rf_ready)
                  state_q <= serv_pkg::ST_EXEC;
            end
            default: begin
               if (cnt.cnt_done)
                  state_q <= serv_pkg::ST_FETCH;
            end
         endcase
         // Wraps back to zero after bit 31
         if (cnt.cnt_en)
            cnt_q <= cnt_q + 1'b1;
      end
   end

   // Bus request raised again straight after the last execute bit
   always_ff @(posedge i_clk) begin
      if (!i_rst_n)
         o_ibus_cyc <= 1'b0;
      else if (o_ibus_cyc && i_ibus_ack)
         o_ibus_cyc <= 1'b0;
      else if (cnt.cnt_done || state_q == serv_pkg::ST_FETCH)
         o_ibus_cyc <= 1'b1;
   end

   a_rreq_not_exec : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_rf_rreq |-> (!cnt.cnt_en && !o_ibus_cyc));

   a_done_ends_exec : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      cnt.cnt_done |-> cnt.cnt_en ##1 (!cnt.cnt_en && o_ibus_cyc));

endmodule

/* verilog/serv_top.sv */
`timescale 1ns/1ps

module serv_top (
   input  logic                            i_clk,
   input  logic                            i_rst_n,
   // Instruction bus
   output logic [serv_pkg::XLEN-1:0]       o_ibus_adr,
   output logic                            o_ibus_cyc,
   input  logic [serv_pkg::XLEN-1:0]       i_ibus_rdt,
   input  logic                            i_ibus_ack,
   // Register file
   output logic                            o_rf_rreq,
   input  logic                            i_rf_ready,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rreg0,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rreg1,
   input  logic                            i_rdata0,
   input  logic                            i_rdata1,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_wreg0,
   output logic                            o_wen0,
   output logic                            o_wdata0
);

   logic                            rf_busy;
   logic [serv_pkg::REG_ADDR_W-1:0] rs1_addr;
   logic [serv_pkg::REG_ADDR_W-1:0] rs2_addr;
   logic [serv_pkg::REG_ADDR_W-1:0] rd_addr;
   logic                            rd_wr;
   logic                            rd_ctrl_sel;
   logic                            imm;
   logic                            pc_rel;
   logic                            utype;
   logic                            jal;
   logic                            alu_rd;
   logic                            ctrl_rd;

   serv_cnt_if cnt_bus ();
   serv_alu_if alu_bus ();

   serv_state state (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .o_rf_busy  (rf_busy),
      .cnt        (cnt_bus)
   );

   serv_decode decode (
      .i_clk         (i_clk),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_ibus_ack    (i_ibus_ack),
      .cnt           (cnt_bus),
      .alu           (alu_bus),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .o_rd_addr     (rd_addr),
      .o_rd_wr       (rd_wr),
      .o_imm         (imm),
      .o_ctrl_pc_rel (pc_rel),
      .o_ctrl_utype  (utype),
      .o_ctrl_jal    (jal),
      .o_rd_ctrl_sel (rd_ctrl_sel)
   );

   serv_alu alu (
      .i_clk (i_clk),
      .cnt   (cnt_bus),
      .alu   (alu_bus),
      .i_rs1 (i_rdata0),
      .i_rs2 (i_rdata1),
      .i_imm (imm),
      .o_rd  (alu_rd)
   );

   serv_ctrl ctrl (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .cnt        (cnt_bus),
      .i_imm      (imm),
      .i_pc_rel   (pc_rel),
      .i_utype    (utype),
      .i_jal      (jal),
      .o_rd       (ctrl_rd),
      .o_ibus_adr (o_ibus_adr)
   );

   serv_rf_if rf_if (
      .i_rf_busy     (rf_busy),
      .i_rd_wr       (rd_wr),
      .i_rd_ctrl_sel (rd_ctrl_sel),
      .i_rd_addr     (rd_addr),
      .i_rs1_addr    (rs1_addr),
      .i_rs2_addr    (rs2_addr),
      .i_alu_rd      (alu_rd),
      .i_ctrl_rd     (ctrl_rd),
      .o_wreg0       (o_wreg0),
      .o_wen0        (o_wen0),
      .o_wdata0      (o_wdata0),
      .o_rreg0       (o_rreg0),
      .o_rreg1       (o_rreg1)
   );

endmodule
